// ==== source/host_chan_pkg.sv ====
//****************************************
// Host write channel definitions: line
// address, request tag and DSM line views
//****************************************

`default_nettype none

package host_chan_pkg;

    // One host line carries 128 data bits
    localparam int LINE_BITS = 128;
    localparam int ADDR_BITS = 32;
    localparam int MDATA_BITS = 16;

    // Host addresses count whole lines, not bytes
    typedef logic [ADDR_BITS-1:0] line_addr_t;
    typedef logic [MDATA_BITS-1:0] mdata_t;

    // Every write injected by the driver carries this tag
    // User logic must never issue a request with tag 0
    localparam mdata_t DRIVER_WRITE_TAG = 16'd0;

    // Status reply layout inside DSM line 1
    typedef struct packed {
        logic [62:0] pad;
        logic        written;
        logic [63:0] value;
    } dsm_status_t;

    // DSM line 0 holds the identifier, line 1 a status reply
    typedef union packed {
        logic [LINE_BITS-1:0] afu_id;
        dsm_status_t          status;
    } dsm_line_u;

endpackage

`default_nettype wire

// ==== source/driver_csr_pkg.sv ====
//****************************************
// Driver register map, status indices
// and accelerator identifier
//****************************************

`default_nettype none

package driver_csr_pkg;

    localparam int CSR_ADDR_BITS = 3;
    localparam int CSR_DATA_BITS = 32;

    // Word address and data on the Wishbone register port
    typedef logic [CSR_ADDR_BITS-1:0] csr_addr_t;
    typedef logic [CSR_DATA_BITS-1:0] csr_data_t;

    // Register map
    localparam csr_addr_t REG_DSM_BASE = 3'd0;
    localparam csr_addr_t REG_ENG_BASE = 3'd1;
    localparam csr_addr_t REG_ENG_COUNT = 3'd2;
    localparam csr_addr_t REG_ENG_CTRL = 3'd3;
    localparam csr_addr_t REG_SREG_INDEX = 3'd4;

    // Status reply value written back to the DSM
    typedef logic [63:0] sreg_t;

    // Status register indices, anything else reads as zero
    localparam csr_data_t SREG_WRITES_ISSUED = 32'd0;
    localparam csr_data_t SREG_RESPONSES_SEEN = 32'd1;
    localparam csr_data_t SREG_DSM_BASE = 32'd2;

    // Identifier that software looks for in DSM line 0
    localparam logic [127:0] AFU_ID = 128'h6c1e_93a4_2f0b_47d8_b5e2_0a9c_3d71_e846;

endpackage

`default_nettype wire

// ==== source/driver_csr_regs.sv ====
//****************************************
// Wishbone register block holding the DSM
// base, engine setup and status replies
//****************************************

`timescale 1ns/1ps
`default_nettype none

module driver_csr_regs
(
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        wb_cyc,
    input  logic                        wb_stb,
    input  logic                        wb_we,
    input  driver_csr_pkg::csr_addr_t   wb_adr,
    input  driver_csr_pkg::csr_data_t   wb_dat_w,
    output driver_csr_pkg::csr_data_t   wb_dat_r,
    output logic                        wb_ack,
    input  logic                        eng_busy,
    input  logic                        eng_done,
    input  driver_csr_pkg::sreg_t       writes_issued,
    input  driver_csr_pkg::sreg_t       responses_seen,
    output host_chan_pkg::line_addr_t   dsm_base,
    output logic                        dsm_base_valid,
    output host_chan_pkg::line_addr_t   eng_base,
    output driver_csr_pkg::csr_data_t   eng_count,
    output logic                        eng_start,
    output driver_csr_pkg::sreg_t       sreg_rsp,
    output logic                        sreg_rsp_enable
);
    import host_chan_pkg::*;
    import driver_csr_pkg::*;

    logic      access;
    logic      wr_access;
    logic      rd_access;
    logic      sreg_req;
    csr_data_t sreg_index;
    csr_data_t rd_data;
    sreg_t     sreg_sel;

    // A new bus cycle is taken only while ack is low, so each access lasts two clocks
    assign access = wb_cyc && wb_stb && !wb_ack;
    assign wr_access = access && wb_we;
    assign rd_access = access && !wb_we;

    // Register writes land on the same edge that raises ack
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wb_ack <= 1'b0;
            dsm_base <= '0;
            dsm_base_valid <= 1'b0;
            eng_base <= '0;
            eng_count <= '0;
            sreg_index <= '0;
            eng_start <= 1'b0;
            sreg_req <= 1'b0;
            sreg_rsp_enable <= 1'b0;
        end
        else
        begin
            wb_ack <= access;
            // Start and status request are single-cycle strobes
            eng_start <= wr_access && (wb_adr == REG_ENG_CTRL) && wb_dat_w[0];
            sreg_req <= wr_access && (wb_adr == REG_SREG_INDEX);
            // The reply follows one cycle after the acknowledged index write
            sreg_rsp_enable <= sreg_req;
            if (wr_access)
            begin
                case (wb_adr)
                    REG_DSM_BASE:
                    begin
                        dsm_base <= line_addr_t'(wb_dat_w);
                        dsm_base_valid <= 1'b1;
                    end
                    REG_ENG_BASE: eng_base <= line_addr_t'(wb_dat_w);
                    REG_ENG_COUNT: eng_count <= wb_dat_w;
                    REG_SREG_INDEX: sreg_index <= wb_dat_w;
                    default: ;
                endcase
            end
        end
    end

    // Read mux, the engine control word reports busy and done
    always_comb
    begin
        case (wb_adr)
            REG_DSM_BASE: rd_data = csr_data_t'(dsm_base);
            REG_ENG_BASE: rd_data = csr_data_t'(eng_base);
            REG_ENG_COUNT: rd_data = eng_count;
            REG_ENG_CTRL: rd_data = {30'd0, eng_done, eng_busy};
            REG_SREG_INDEX: rd_data = sreg_index;
            default: rd_data = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rd_access)
        begin
            wb_dat_r <= rd_data;
        end
    end

    // Status value selected by the latched index
    always_comb
    begin
        case (sreg_index)
            SREG_WRITES_ISSUED: sreg_sel = writes_issued;
            SREG_RESPONSES_SEEN: sreg_sel = responses_seen;
            SREG_DSM_BASE: sreg_sel = sreg_t'(dsm_base);
            default: sreg_sel = '0;
        endcase
    end

    // Value is sampled alongside the enable strobe
    always_ff @(posedge clk)
    begin
        if (sreg_req)
        begin
            sreg_rsp <= sreg_sel;
        end
    end

endmodule

`default_nettype wire

// ==== source/host_channel_tap.sv ====
//****************************************
// Host channel tap: passes user writes,
// fills idle slots with DSM writes and
// hides the driver's own write responses
//****************************************

`timescale 1ns/1ps
`default_nettype none

module host_channel_tap
(
    input  logic                                clk,
    input  logic                                reset_n,
    input  logic                                afu_wr_valid,
    input  host_chan_pkg::line_addr_t           afu_addr,
    input  host_chan_pkg::mdata_t               afu_mdata,
    input  logic [host_chan_pkg::LINE_BITS-1:0] afu_data,
    input  logic                                tx_alm_full,
    input  logic                                rx_wr_valid,
    input  host_chan_pkg::mdata_t               rx_mdata,
    input  host_chan_pkg::line_addr_t           dsm_base,
    input  logic                                dsm_base_valid,
    input  driver_csr_pkg::sreg_t               sreg_rsp,
    input  logic                                sreg_rsp_enable,
    output logic                                tx_wr_valid,
    output host_chan_pkg::line_addr_t           tx_addr,
    output host_chan_pkg::mdata_t               tx_mdata,
    output logic [host_chan_pkg::LINE_BITS-1:0] tx_data,
    output logic                                afu_alm_full,
    output logic                                afu_rx_valid,
    output host_chan_pkg::mdata_t               afu_rx_mdata
);
    import host_chan_pkg::*;
    import driver_csr_pkg::*;

    logic      did_afu_id_write;
    logic      id_pending;
    logic      slot_free;
    logic      send_id;
    logic      send_sreg;
    logic      sreg_rsp_enable_q;
    sreg_t     sreg_rsp_q;
    dsm_line_u id_line;
    dsm_line_u sreg_line;

    // User logic sees the host's back-pressure unchanged
    assign afu_alm_full = tx_alm_full;

    // A slot is free when the user is silent and the host can take a request
    assign slot_free = !afu_wr_valid && !tx_alm_full;

    // Identifier goes out once, as soon as the DSM base is known
    assign id_pending = dsm_base_valid && !did_afu_id_write;
    assign send_id = slot_free && id_pending;

    // Status reply waits behind a pending identifier write
    assign send_sreg = slot_free && !id_pending && sreg_rsp_enable_q;

    // DSM line images built through the two union views
    always_comb
    begin
        id_line.afu_id = AFU_ID;
        sreg_line = '0;
        sreg_line.status.value = sreg_rsp_q;
        sreg_line.status.written = 1'b1;
    end

    // Request merge, user traffic passes straight through by default
    always_comb
    begin
        tx_wr_valid = afu_wr_valid;
        tx_addr = afu_addr;
        tx_mdata = afu_mdata;
        tx_data = afu_data;
        if (send_id)
        begin
            tx_wr_valid = 1'b1;
            tx_addr = dsm_base;
            tx_mdata = DRIVER_WRITE_TAG;
            tx_data = id_line;
        end
        else if (send_sreg)
        begin
            // Status replies land in DSM line 1
            tx_wr_valid = 1'b1;
            tx_addr = dsm_base + line_addr_t'(1);
            tx_mdata = DRIVER_WRITE_TAG;
            tx_data = sreg_line;
        end
    end

    // Responses to driver writes never reach the user logic
    assign afu_rx_valid = rx_wr_valid && (rx_mdata != DRIVER_WRITE_TAG);
    assign afu_rx_mdata = rx_mdata;

    // The identifier flag only sets when the write really leaves
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            did_afu_id_write <= 1'b0;
        end
        else if (send_id)
        begin
            did_afu_id_write <= 1'b1;
        end
    end

    // One status reply held at a time, later strobes are dropped while it waits
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            sreg_rsp_enable_q <= 1'b0;
        end
        else if (send_sreg)
        begin
            sreg_rsp_enable_q <= 1'b0;
        end
        else if (!sreg_rsp_enable_q)
        begin
            sreg_rsp_enable_q <= sreg_rsp_enable;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!sreg_rsp_enable_q && sreg_rsp_enable)
        begin
            sreg_rsp_q <= sreg_rsp;
        end
    end

endmodule

`default_nettype wire

// ==== source/afu_write_engine.sv ====
//****************************************
// User write engine: fills a range of host
// lines and counts their write responses
//****************************************

`timescale 1ns/1ps
`default_nettype none

module afu_write_engine
(
    input  logic                                clk,
    input  logic                                reset_n,
    input  host_chan_pkg::line_addr_t           eng_base,
    input  driver_csr_pkg::csr_data_t           eng_count,
    input  logic                                eng_start,
    input  logic                                afu_alm_full,
    input  logic                                afu_rx_valid,
    input  host_chan_pkg::mdata_t               afu_rx_mdata,
    output logic                                afu_wr_valid,
    output host_chan_pkg::line_addr_t           afu_addr,
    output host_chan_pkg::mdata_t               afu_mdata,
    output logic [host_chan_pkg::LINE_BITS-1:0] afu_data,
    output logic                                eng_busy,
    output logic                                eng_done,
    output driver_csr_pkg::sreg_t               writes_issued,
    output driver_csr_pkg::sreg_t               responses_seen
);
    import host_chan_pkg::*;
    import driver_csr_pkg::*;

    logic       active;
    logic       rsp_in_run;
    csr_data_t  line_idx;
    csr_data_t  run_count;
    line_addr_t run_base;

    // One line per cycle while busy and the host is not almost full
    assign afu_wr_valid = eng_busy && !afu_alm_full;
    assign afu_addr = run_base + line_idx;

    // Tags start at 1, tag 0 belongs to the driver
    assign afu_mdata = mdata_t'(line_idx + 32'd1);
    assign afu_data = {(LINE_BITS / 32){line_idx}};

    // Only responses whose tag falls inside the current run are counted
    assign rsp_in_run = afu_rx_valid && (csr_data_t'(afu_rx_mdata) <= run_count);

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            eng_busy <= 1'b0;
            eng_done <= 1'b0;
            active <= 1'b0;
            line_idx <= '0;
            run_count <= '0;
            run_base <= '0;
            writes_issued <= '0;
            responses_seen <= '0;
        end
        else if (eng_start && !active)
        begin
            // Setup is captured so a register rewrite cannot disturb the run
            eng_busy <= (eng_count != '0);
            eng_done <= 1'b0;
            active <= 1'b1;
            line_idx <= '0;
            run_count <= eng_count;
            run_base <= eng_base;
            writes_issued <= '0;
            responses_seen <= '0;
        end
        else
        begin
            if (afu_wr_valid)
            begin
                line_idx <= line_idx + 32'd1;
                writes_issued <= writes_issued + sreg_t'(1);
                // Busy drops once the final line has been sent
                if (line_idx + 32'd1 == run_count)
                begin
                    eng_busy <= 1'b0;
                end
            end
            if (rsp_in_run)
            begin
                responses_seen <= responses_seen + sreg_t'(1);
            end
            // Run completes when every line has been answered
            if (active && !eng_busy && (responses_seen == sreg_t'(run_count)))
            begin
                eng_done <= 1'b1;
                active <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/driver_top.sv ====
//****************************************
// Driver shell top: register block, host
// channel tap and user write engine
//****************************************

`timescale 1ns/1ps
`default_nettype none

module driver_top
(
    input  logic                                clk,
    input  logic                                reset_n,
    input  logic                                wb_cyc,
    input  logic                                wb_stb,
    input  logic                                wb_we,
    input  driver_csr_pkg::csr_addr_t           wb_adr,
    input  driver_csr_pkg::csr_data_t           wb_dat_w,
    output driver_csr_pkg::csr_data_t           wb_dat_r,
    output logic                                wb_ack,
    input  logic                                tx_alm_full,
    output logic                                tx_wr_valid,
    output host_chan_pkg::line_addr_t           tx_addr,
    output host_chan_pkg::mdata_t               tx_mdata,
    output logic [host_chan_pkg::LINE_BITS-1:0] tx_data,
    input  logic                                rx_wr_valid,
    input  host_chan_pkg::mdata_t               rx_mdata
);
    import host_chan_pkg::*;
    import driver_csr_pkg::*;

    // Register block to tap
    line_addr_t           dsm_base;
    logic                 dsm_base_valid;
    sreg_t                sreg_rsp;
    logic                 sreg_rsp_enable;

    // Register block to engine and back
    line_addr_t           eng_base;
    csr_data_t            eng_count;
    logic                 eng_start;
    logic                 eng_busy;
    logic                 eng_done;
    sreg_t                writes_issued;
    sreg_t                responses_seen;

    // Engine write path and filtered responses through the tap
    logic                 afu_wr_valid;
    line_addr_t           afu_addr;
    mdata_t               afu_mdata;
    logic [LINE_BITS-1:0] afu_data;
    logic                 afu_alm_full;
    logic                 afu_rx_valid;
    mdata_t               afu_rx_mdata;

    driver_csr_regs driver_csr_regs_inst (.*);

    host_channel_tap host_channel_tap_inst (.*);

    afu_write_engine afu_write_engine_inst (.*);

endmodule

`default_nettype wire

// ==== sim/host_memory_model.sv ====
//****************************************
// Host memory model: accepts write requests,
// answers each with its tag after a random
// delay and throttles with almost-full
//****************************************

`timescale 1ns/1ps
`default_nettype none

module host_memory_model
#(
    parameter logic [31:0] SEED = 32'd82416
)
(
    input  logic                                clk,
    input  logic                                reset_n,
    input  logic                                tx_wr_valid,
    input  host_chan_pkg::line_addr_t           tx_addr,
    input  host_chan_pkg::mdata_t               tx_mdata,
    input  logic [host_chan_pkg::LINE_BITS-1:0] tx_data,
    output logic                                tx_alm_full,
    output logic                                rx_wr_valid,
    output host_chan_pkg::mdata_t               rx_mdata
);
    import host_chan_pkg::*;

    // Galois LFSR state, it runs freely through reset
    logic [31:0] lfsr_state = SEED;

    // Values prepared at the rising edge and driven at the falling edge
    logic        rsp_valid_next = 1'b0;
    mdata_t      rsp_tag_next = '0;
    logic        alm_full_next = 1'b0;
    logic        alm_full_r = 1'b0;
    logic        rx_valid_r = 1'b0;
    mdata_t      rx_mdata_r = '0;

    int unsigned cycle = 0;
    int unsigned stall_left = 0;
    int unsigned delay;
    int unsigned stall_pick;

    // Pending responses in arrival order, each with the cycle it falls due
    mdata_t      rsp_tag_q[$];
    int unsigned rsp_due_q[$];

    // Every accepted request
    line_addr_t           req_addr[$];
    mdata_t               req_mdata[$];
    logic [LINE_BITS-1:0] req_data[$];
    int unsigned          req_count = 0;

    // One step of a 32-bit Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0])
        begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    // Takes count bits, stepping the LFSR once for each bit
    task automatic draw_bits(input int count, output int unsigned value);
        value = 0;
        for (int i = 0; i < count; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    always @(posedge clk)
    begin
        if (!reset_n)
        begin
            rsp_tag_q.delete();
            rsp_due_q.delete();
            stall_left = 0;
            rsp_valid_next = 1'b0;
            alm_full_next = 1'b0;
        end
        else
        begin
            cycle++;
            if (tx_wr_valid)
            begin
                req_addr.push_back(tx_addr);
                req_mdata.push_back(tx_mdata);
                req_data.push_back(tx_data);
                req_count++;
                // Answer after 1 to 8 cycles
                draw_bits(3, delay);
                rsp_tag_q.push_back(tx_mdata);
                rsp_due_q.push_back(cycle + delay + 1);
            end
            // At most one response pulse per cycle, oldest first
            if ((rsp_due_q.size() != 0) && (rsp_due_q[0] <= cycle))
            begin
                rsp_valid_next = 1'b1;
                rsp_tag_next = rsp_tag_q.pop_front();
                void'(rsp_due_q.pop_front());
            end
            else
            begin
                rsp_valid_next = 1'b0;
            end
            // Roughly one cycle in eight starts an almost-full stretch of 1 to 4 cycles
            if (stall_left == 0)
            begin
                draw_bits(3, stall_pick);
                if (stall_pick == 0)
                begin
                    draw_bits(2, stall_left);
                    stall_left = stall_left + 1;
                end
            end
            alm_full_next = (stall_left != 0);
            if (stall_left != 0)
            begin
                stall_left--;
            end
        end
    end

    always @(negedge clk)
    begin
        alm_full_r = alm_full_next;
        rx_valid_r = rsp_valid_next;
        rx_mdata_r = rsp_tag_next;
    end

    assign tx_alm_full = alm_full_r;
    assign rx_wr_valid = rx_valid_r;
    assign rx_mdata = rx_mdata_r;

endmodule

`default_nettype wire

// ==== sim/driver_tb.sv ====
//****************************************
// Testbench for the driver shell: programs
// the registers, runs the write engine and
// checks every host request
//****************************************

`timescale 1ns/1ps
`default_nettype none

module driver_tb;
    import host_chan_pkg::*;
    import driver_csr_pkg::*;

    localparam int NUM_LINES = 20;
    // Generous budget per engine line, covers setup and status traffic
    localparam int TIMEOUT_CYCLES = NUM_LINES * 200;
    localparam line_addr_t DSM_BASE_ADDR = 32'h0000_1000;
    localparam line_addr_t ENG_BASE_ADDR = 32'h0000_2000;

    logic                 clk;
    logic                 reset_n;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic                 wb_we;
    csr_addr_t            wb_adr;
    csr_data_t            wb_dat_w;
    csr_data_t            wb_dat_r;
    logic                 wb_ack;
    logic                 tx_alm_full;
    logic                 tx_wr_valid;
    line_addr_t           tx_addr;
    mdata_t               tx_mdata;
    logic [LINE_BITS-1:0] tx_data;
    logic                 rx_wr_valid;
    mdata_t               rx_mdata;

    int unsigned cycle_count;
    int unsigned monitor_errors = 0;
    int unsigned flow_errors = 0;
    int unsigned id_writes = 0;
    int unsigned status_writes = 0;
    int unsigned lines_seen = 0;
    logic        ack_prev = 1'b0;
    sreg_t       exp_sreg = '0;

    driver_top driver_top_inst (.*);

    host_memory_model host_memory_model_inst (.*);

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input string test_name, input logic [127:0] expected,
                               input logic [127:0] actual);
        assert (actual === expected)
        else
        begin
            $display("Mismatch %s: expected %h actual %h", test_name, expected, actual);
            monitor_errors++;
        end
    endtask

    // Sorts a request into identifier, status reply or engine line
    task automatic check_request();
        int unsigned idx;
        idx = lines_seen;
        if (tx_mdata == DRIVER_WRITE_TAG)
        begin
            if (tx_addr == DSM_BASE_ADDR)
            begin
                id_writes++;
                check_value("identifier line", AFU_ID, tx_data);
            end
            else if (tx_addr == DSM_BASE_ADDR + line_addr_t'(1))
            begin
                // Written flag at bit 64 above the 64-bit value
                status_writes++;
                check_value("status line", {63'd0, 1'b1, exp_sreg}, tx_data);
            end
            else
            begin
                $display("Driver-tagged write to unexpected address %h", tx_addr);
                monitor_errors++;
            end
        end
        else
        begin
            check_value("engine address", 128'(ENG_BASE_ADDR + line_addr_t'(idx)), 128'(tx_addr));
            check_value("engine tag", 128'(idx + 1), 128'(tx_mdata));
            check_value("engine data", {4{idx}}, tx_data);
            lines_seen++;
        end
    endtask

    // Walks the host's own record of accepted requests and counts each kind
    task automatic check_host_record();
        int unsigned rec_id;
        int unsigned rec_status;
        int unsigned rec_lines;
        rec_id = 0;
        rec_status = 0;
        rec_lines = 0;
        for (int i = 0; i < int'(host_memory_model_inst.req_count); i++)
        begin
            if (host_memory_model_inst.req_mdata[i] != DRIVER_WRITE_TAG)
            begin
                rec_lines++;
            end
            else if (host_memory_model_inst.req_addr[i] == DSM_BASE_ADDR)
            begin
                rec_id++;
                check_value("recorded identifier", AFU_ID,
                            host_memory_model_inst.req_data[i]);
            end
            else
            begin
                rec_status++;
            end
        end
        // One identifier, the held status reply plus the final one, and every engine line
        assert ((rec_id == 1) && (rec_status == 2) && (rec_lines == NUM_LINES))
        else
        begin
            $display("Host recorded %0d identifier, %0d status and %0d line writes",
                     rec_id, rec_status, rec_lines);
            $display("Expected 1 identifier, 2 status and %0d line writes", NUM_LINES);
            flow_errors++;
        end
    endtask

    // Samples at the rising edge, where the accepted request is settled
    always @(posedge clk)
    begin
        if (reset_n)
        begin
            assert (!(tx_wr_valid && tx_alm_full))
            else
            begin
                $display("Request raised while tx_alm_full was high at %0t", $time);
                monitor_errors++;
            end
            assert (!(wb_ack && ack_prev))
            else
            begin
                $display("Wishbone ack stayed high for more than one cycle at %0t", $time);
                monitor_errors++;
            end
            ack_prev = wb_ack;
            if (tx_wr_valid)
            begin
                check_request();
            end
        end
    end

    // Classic single write, stb drops in the cycle ack is seen
    task automatic wb_write(input csr_addr_t addr, input csr_data_t data);
        @(negedge clk);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = 1'b1;
        wb_adr = addr;
        wb_dat_w = data;
        @(negedge clk);
        while (!wb_ack)
        begin
            @(negedge clk);
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    task automatic wb_read(input csr_addr_t addr, output csr_data_t data);
        @(negedge clk);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = 1'b0;
        wb_adr = addr;
        @(negedge clk);
        while (!wb_ack)
        begin
            @(negedge clk);
        end
        data = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic report_counts();
        $display("Errors: %0d request, %0d sequence; %0d lines, %0d status writes, %0d id writes",
                 monitor_errors, flow_errors, lines_seen, status_writes, id_writes);
    endtask

    // Hard limit on the run
    initial
    begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the run did not complete", TIMEOUT_CYCLES);
        report_counts();
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial
    begin
        csr_data_t   rd_data;
        int unsigned prev_status;
        reset_n = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        // The identifier goes out once the DSM base is known
        wb_write(REG_DSM_BASE, csr_data_t'(DSM_BASE_ADDR));
        while (id_writes < 1)
        begin
            @(negedge clk);
        end

        // Engine setup, read back over the register port
        wb_write(REG_ENG_BASE, csr_data_t'(ENG_BASE_ADDR));
        wb_write(REG_ENG_COUNT, csr_data_t'(NUM_LINES));
        wb_read(REG_ENG_BASE, rd_data);
        assert (rd_data == csr_data_t'(ENG_BASE_ADDR))
        else
        begin
            $display("Mismatch eng base readback: expected %h actual %h", ENG_BASE_ADDR, rd_data);
            flow_errors++;
        end
        wb_read(REG_ENG_COUNT, rd_data);
        assert (rd_data == csr_data_t'(NUM_LINES))
        else
        begin
            $display("Mismatch eng count readback: expected %0d actual %0d", NUM_LINES, rd_data);
            flow_errors++;
        end

        // Two status requests during the run, the second finds one held and is dropped
        exp_sreg = sreg_t'(DSM_BASE_ADDR);
        wb_write(REG_ENG_CTRL, 32'd1);
        wb_write(REG_SREG_INDEX, SREG_DSM_BASE);
        wb_write(REG_SREG_INDEX, SREG_DSM_BASE);

        rd_data = '0;
        while (!rd_data[1])
        begin
            wb_read(REG_ENG_CTRL, rd_data);
        end
        assert ((lines_seen == NUM_LINES) && !rd_data[0])
        else
        begin
            $display("Engine reported done with %0d of %0d lines sent", lines_seen, NUM_LINES);
            flow_errors++;
        end
        while (status_writes < 1)
        begin
            @(negedge clk);
        end
        assert (status_writes == 1)
        else
        begin
            $display("Mismatch held status writes: expected 1 actual %0d", status_writes);
            flow_errors++;
        end

        // Responses seen must equal the line count, so driver responses were filtered
        exp_sreg = sreg_t'(NUM_LINES);
        prev_status = status_writes;
        wb_write(REG_SREG_INDEX, SREG_RESPONSES_SEEN);
        while (status_writes == prev_status)
        begin
            @(negedge clk);
        end

        check_host_record();

        report_counts();
        if (monitor_errors + flow_errors == 0)
        begin
            $display("TEST RESULT: PASS");
        end
        else
        begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
source/host_chan_pkg.sv
source/driver_csr_pkg.sv
source/driver_csr_regs.sv
source/host_channel_tap.sv
source/afu_write_engine.sv
source/driver_top.sv
sim/host_memory_model.sv
sim/driver_tb.sv

// ==== Makefile ====
# Verilator build and run for the driver shell testbench

VERILATOR ?= verilator
TOP       ?= driver_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
